// File: rtl/ps_bus_pkg.sv
/*
 * Shared AXI and system bus types for the PS wrapper.
 * AXI side carries single-beat transfers only (no len, burst or last).
 * Region code sits in address bits 22..20, offset in the bits below.
 */
`default_nettype none

package ps_bus_pkg;

  // Meaningful widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [ 3:0] strb_t;
  typedef logic [11:0] axi_id_t;
  typedef logic [ 2:0] region_t;

  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2
  } axi_resp_e;

  // AXI channel payloads
  typedef struct packed {
    axi_id_t id;
    addr_t   addr;
  } axi_aw_t;

  typedef struct packed {
    axi_id_t id;
    addr_t   addr;
  } axi_ar_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } axi_w_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_e resp;
  } axi_b_t;

  typedef struct packed {
    axi_id_t   id;
    data_t     data;
    axi_resp_e resp;
  } axi_r_t;

  // System bus, wen/ren are single-cycle pulses
  typedef struct packed {
    addr_t addr;
    data_t wdata;
    strb_t sel;
    logic  wen;
    logic  ren;
  } sys_req_t;

  typedef struct packed {
    data_t rdata;
    logic  ack;
    logic  err;
  } sys_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_ACK,
    SEND_B,
    SEND_R
  } slave_state_e;

  localparam data_t   HK_ID      = 32'h5250_0001;
  localparam region_t REGION_HK  = 3'd0;
  localparam region_t REGION_RAM = 3'd1;

  // Byte-lane merge under a strobe mask
  function automatic data_t merge_strb(data_t old_word, data_t new_word, strb_t strb);
    data_t res;
    res = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// File: rtl/axi_gp_slave.sv
/*
 * Single-beat AXI slave that masters the system bus.
 * Burst length is assumed zero and WLAST is not looked at.
 * One transaction in flight; reads win over writes when both wait.
 */
`timescale 1ns/1ps
`default_nettype none

module axi_gp_slave (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  // Write address / data
  input  wire ps_bus_pkg::axi_aw_t  aw,
  input  wire logic                 aw_valid,
  output logic                      aw_ready,
  input  wire ps_bus_pkg::axi_w_t   w,
  input  wire logic                 w_valid,
  output logic                      w_ready,
  // Write response
  output ps_bus_pkg::axi_b_t        b,
  output logic                      b_valid,
  input  wire logic                 b_ready,
  // Read address
  input  wire ps_bus_pkg::axi_ar_t  ar,
  input  wire logic                 ar_valid,
  output logic                      ar_ready,
  // Read data
  output ps_bus_pkg::axi_r_t        r,
  output logic                      r_valid,
  input  wire logic                 r_ready,
  // System bus master side
  output ps_bus_pkg::sys_req_t      req,
  input  wire ps_bus_pkg::sys_rsp_t rsp
);

  ////////////////////////////////////////////////////////////////////////////
  // Handshake decode
  ////////////////////////////////////////////////////////////////////////////

  ps_bus_pkg::slave_state_e state_q;

  logic ar_hs;
  logic aw_hs;

  // Control
  logic is_rd_q;
  logic wen_q;
  logic ren_q;

  // Latched payload
  ps_bus_pkg::axi_id_t   id_q;
  ps_bus_pkg::addr_t     addr_q;
  ps_bus_pkg::data_t     wdata_q;
  ps_bus_pkg::strb_t     strb_q;
  ps_bus_pkg::data_t     rdata_q;
  ps_bus_pkg::axi_resp_e resp_q;

  // Reads take priority, so write ready stays low while ARVALID is up
  assign ar_ready = (state_q == ps_bus_pkg::IDLE) && ar_valid;
  assign aw_ready = (state_q == ps_bus_pkg::IDLE) && !ar_valid && aw_valid && w_valid;
  // AW and W accepted together
  assign w_ready  = aw_ready;

  assign ar_hs = ar_valid && ar_ready;
  assign aw_hs = aw_valid && aw_ready;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ps_bus_pkg::IDLE;
      is_rd_q <= 1'b0;
      wen_q   <= 1'b0;
      ren_q   <= 1'b0;
    end else begin
      // Bus strobes are single pulses
      wen_q <= 1'b0;
      ren_q <= 1'b0;
      case (state_q)
        ps_bus_pkg::IDLE: begin
          if (ar_hs) begin
            is_rd_q <= 1'b1;
            ren_q   <= 1'b1;
            state_q <= ps_bus_pkg::WAIT_ACK;
          end else if (aw_hs) begin
            is_rd_q <= 1'b0;
            wen_q   <= 1'b1;
            state_q <= ps_bus_pkg::WAIT_ACK;
          end
        end
        ps_bus_pkg::WAIT_ACK: begin
          // Wait for the responder, however long it takes
          if (rsp.ack) begin
            state_q <= is_rd_q ? ps_bus_pkg::SEND_R : ps_bus_pkg::SEND_B;
          end
        end
        ps_bus_pkg::SEND_B: begin
          if (b_ready) begin
            state_q <= ps_bus_pkg::IDLE;
          end
        end
        ps_bus_pkg::SEND_R: begin
          if (r_ready) begin
            state_q <= ps_bus_pkg::IDLE;
          end
        end
        default: state_q <= ps_bus_pkg::IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Payload capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      id_q   <= ar.id;
      addr_q <= ar.addr;
    end else if (aw_hs) begin
      id_q    <= aw.id;
      addr_q  <= aw.addr;
      wdata_q <= w.data;
      strb_q  <= w.strb;
    end
    // Response captured once, held steady through back-pressure
    if ((state_q == ps_bus_pkg::WAIT_ACK) && rsp.ack) begin
      resp_q  <= rsp.err ? ps_bus_pkg::SLVERR : ps_bus_pkg::OKAY;
      // Erroring read returns zero
      rdata_q <= rsp.err ? '0 : rsp.rdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign req.addr  = addr_q;
  assign req.wdata = wdata_q;
  assign req.sel   = strb_q;
  assign req.wen   = wen_q;
  assign req.ren   = ren_q;

  assign b_valid = (state_q == ps_bus_pkg::SEND_B);
  assign b.id    = id_q;
  assign b.resp  = resp_q;

  assign r_valid = (state_q == ps_bus_pkg::SEND_R);
  assign r.id    = id_q;
  assign r.data  = rdata_q;
  assign r.resp  = resp_q;

endmodule

`default_nettype wire

// File: rtl/sys_bus_decoder.sv
/*
 * Address-region router for the system bus.
 * Region = addr[22:20]; unmapped regions answer with err one cycle later.
 * Assumes only one request outstanding at a time.
 */
`timescale 1ns/1ps
`default_nettype none

module sys_bus_decoder (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire ps_bus_pkg::sys_req_t req,
  output ps_bus_pkg::sys_rsp_t      rsp,
  // Housekeeping
  output ps_bus_pkg::sys_req_t      hk_req,
  input  wire ps_bus_pkg::sys_rsp_t hk_rsp,
  // Data memory
  output ps_bus_pkg::sys_req_t      ram_req,
  input  wire ps_bus_pkg::sys_rsp_t ram_rsp
);

  ps_bus_pkg::region_t region;
  ps_bus_pkg::region_t sel_q;

  logic hit_hk;
  logic hit_ram;
  logic err_ack_q;

  assign region  = req.addr[22:20];
  assign hit_hk  = (region == ps_bus_pkg::REGION_HK);
  assign hit_ram = (region == ps_bus_pkg::REGION_RAM);

  // Strobes only reach the addressed peripheral
  always_comb begin
    hk_req      = req;
    hk_req.wen  = req.wen & hit_hk;
    hk_req.ren  = req.ren & hit_hk;
    ram_req     = req;
    ram_req.wen = req.wen & hit_ram;
    ram_req.ren = req.ren & hit_ram;
  end

  // Remember who owns the pending response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_q     <= ps_bus_pkg::REGION_HK;
      err_ack_q <= 1'b0;
    end else begin
      if (req.wen || req.ren) begin
        sel_q <= region;
      end
      err_ack_q <= (req.wen || req.ren) && !hit_hk && !hit_ram;
    end
  end

  // Response mux
  always_comb begin
    case (sel_q)
      ps_bus_pkg::REGION_HK:  rsp = hk_rsp;
      ps_bus_pkg::REGION_RAM: rsp = ram_rsp;
      default: begin
        rsp.rdata = '0;
        rsp.ack   = err_ack_q;
        rsp.err   = err_ack_q;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/housekeeping_regs.sv
/*
 * Housekeeping registers: ID (RO), LED, scratch.
 * LED_W must be 1..32; LED bits all follow strobe byte 0.
 * Unknown offsets read zero and drop writes, no error.
 */
`timescale 1ns/1ps
`default_nettype none

module housekeeping_regs #(
  parameter int LED_W = 8
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire ps_bus_pkg::sys_req_t req,
  output ps_bus_pkg::sys_rsp_t      rsp,
  output logic [LED_W-1:0]          led
);

  // Word offsets inside the region
  localparam logic [17:0] WORD_ID      = 18'd0;
  localparam logic [17:0] WORD_LED     = 18'd1;
  localparam logic [17:0] WORD_SCRATCH = 18'd2;

  logic [17:0]       word;
  logic [LED_W-1:0]  led_q;
  ps_bus_pkg::data_t scratch_q;
  ps_bus_pkg::data_t rd_word;
  ps_bus_pkg::data_t rdata_q;
  logic              ack_q;

  // Byte bits 1..0 ignored
  assign word = req.addr[19:2];

  ////////////////////////////////////////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      led_q     <= '0;
      scratch_q <= '0;
      ack_q     <= 1'b0;
    end else begin
      ack_q <= req.wen || req.ren;
      if (req.wen) begin
        if ((word == WORD_LED) && req.sel[0]) begin
          led_q <= req.wdata[LED_W-1:0];
        end
        if (word == WORD_SCRATCH) begin
          scratch_q <= ps_bus_pkg::merge_strb(scratch_q, req.wdata, req.sel);
        end
        // ID write acked but has no effect
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Readback
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_word = '0;
    case (word)
      WORD_ID:      rd_word = ps_bus_pkg::HK_ID;
      WORD_LED:     rd_word[LED_W-1:0] = led_q;
      WORD_SCRATCH: rd_word = scratch_q;
      default:      rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (req.ren) begin
      rdata_q <= rd_word;
    end
  end

  assign rsp.rdata = rdata_q;
  assign rsp.ack   = ack_q;
  assign rsp.err   = 1'b0;
  assign led       = led_q;

endmodule

`default_nettype wire

// File: rtl/sys_bus_ram.sv
/*
 * Word RAM on the system bus, byte-masked writes.
 * RAM_DEPTH must be a power of two; addresses alias inside the region.
 * Contents come up undefined.
 */
`timescale 1ns/1ps
`default_nettype none

module sys_bus_ram #(
  parameter int RAM_DEPTH = 64
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire ps_bus_pkg::sys_req_t req,
  output ps_bus_pkg::sys_rsp_t      rsp
);

  localparam int IDX_W = $clog2(RAM_DEPTH);

  ps_bus_pkg::data_t mem [RAM_DEPTH];
  ps_bus_pkg::data_t rdata_q;
  logic [IDX_W-1:0]  idx;
  logic              ack_q;

  // Byte address to word index, upper bits dropped
  assign idx = req.addr[IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (req.wen) begin
      mem[idx] <= ps_bus_pkg::merge_strb(mem[idx], req.wdata, req.sel);
    end
    if (req.ren) begin
      rdata_q <= mem[idx];
    end
  end

  // One-cycle ack
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req.wen || req.ren;
    end
  end

  assign rsp.rdata = rdata_q;
  assign rsp.ack   = ack_q;
  assign rsp.err   = 1'b0;

endmodule

`default_nettype wire

// File: rtl/ps_subsystem_top.sv
/*
 * PL side of the PS wrapper: AXI GP slave, decoder, housekeeping, RAM.
 * Region 0 = housekeeping, region 1 = RAM, others answer SLVERR.
 */
`timescale 1ns/1ps
`default_nettype none

module ps_subsystem_top #(
  parameter int RAM_DEPTH = 64,
  parameter int LED_W     = 8
) (
  input  wire logic                clk,
  input  wire logic                rst_n,
  // AXI GP port
  input  wire ps_bus_pkg::axi_aw_t aw,
  input  wire logic                aw_valid,
  output logic                     aw_ready,
  input  wire ps_bus_pkg::axi_w_t  w,
  input  wire logic                w_valid,
  output logic                     w_ready,
  output ps_bus_pkg::axi_b_t       b,
  output logic                     b_valid,
  input  wire logic                b_ready,
  input  wire ps_bus_pkg::axi_ar_t ar,
  input  wire logic                ar_valid,
  output logic                     ar_ready,
  output ps_bus_pkg::axi_r_t       r,
  output logic                     r_valid,
  input  wire logic                r_ready,
  output logic [LED_W-1:0]         led
);

  //////////////////////////////////////////////////////////////////////////
  // System bus wiring
  //////////////////////////////////////////////////////////////////////////

  ps_bus_pkg::sys_req_t bus_req;
  ps_bus_pkg::sys_rsp_t bus_rsp;
  ps_bus_pkg::sys_req_t hk_req;
  ps_bus_pkg::sys_rsp_t hk_rsp;
  ps_bus_pkg::sys_req_t ram_req;
  ps_bus_pkg::sys_rsp_t ram_rsp;

  axi_gp_slave u_axi_gp_slave (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .req      (bus_req),
    .rsp      (bus_rsp)
  );

  sys_bus_decoder u_sys_bus_decoder (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (bus_req),
    .rsp     (bus_rsp),
    .hk_req  (hk_req),
    .hk_rsp  (hk_rsp),
    .ram_req (ram_req),
    .ram_rsp (ram_rsp)
  );

  // Peripherals
  housekeeping_regs #(
    .LED_W (LED_W)
  ) u_housekeeping_regs (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (hk_req),
    .rsp   (hk_rsp),
    .led   (led)
  );

  sys_bus_ram #(
    .RAM_DEPTH (RAM_DEPTH)
  ) u_sys_bus_ram (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (ram_req),
    .rsp   (ram_rsp)
  );

endmodule

`default_nettype wire

// File: verif/ps_subsystem_tb.sv
/*
 * Testbench for ps_subsystem_top, acting as the AXI GP master.
 * Transactions and expected results come from verif/ps_tests.txt.
 * One transaction at a time; random 0..3 cycle stalls on BREADY/RREADY.
 */
`timescale 1ns/1ps
`default_nettype none

module ps_subsystem_tb;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 16;
  localparam int LED_W      = 8;

  // One line of the tests file
  typedef struct packed {
    logic                is_write;
    ps_bus_pkg::axi_id_t id;
    ps_bus_pkg::addr_t   addr;
    ps_bus_pkg::data_t   data;
    ps_bus_pkg::strb_t   strb;
    ps_bus_pkg::data_t   exp_rdata;
    logic [1:0]          exp_resp;
    logic [LED_W-1:0]    exp_led;
  } test_t;

  logic                clk;
  logic                rst_n;
  ps_bus_pkg::axi_aw_t aw;
  logic                aw_valid;
  logic                aw_ready;
  ps_bus_pkg::axi_w_t  w;
  logic                w_valid;
  logic                w_ready;
  ps_bus_pkg::axi_b_t  b;
  logic                b_valid;
  logic                b_ready;
  ps_bus_pkg::axi_ar_t ar;
  logic                ar_valid;
  logic                ar_ready;
  ps_bus_pkg::axi_r_t  r;
  logic                r_valid;
  logic                r_ready;
  logic [LED_W-1:0]    led;

  test_t       tests[$];
  int unsigned lcg_state   = 79;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          err_count   = 0;
  int          pass_count  = 0;
  int          fail_count  = 0;
  logic        test_bad;
  string       waiting_for = "reset";

  ps_subsystem_top dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .led      (led)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // Watchdog, limit set once the tests file is loaded
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, no handshake seen on %s", cycle_count, waiting_for);
      $display("Done: errors found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic report_mismatch(input string name, input string exp, input string got);
    $display("[FAIL] t=%0t %s expected %s got %s", $time, name, exp, got);
    err_count = err_count + 1;
    test_bad  = 1'b1;
  endtask

  // B viewed in the R layout so both responses share one path
  function automatic ps_bus_pkg::axi_r_t resp_view(input logic is_write);
    ps_bus_pkg::axi_r_t v;
    v = r;
    if (is_write) begin
      v.id   = b.id;
      v.data = '0;
      v.resp = b.resp;
    end
    return v;
  endfunction

  function automatic logic resp_valid(input logic is_write);
    return is_write ? b_valid : r_valid;
  endfunction

  task automatic load_tests();
    int          fd;
    int          n;
    logic        done;
    logic [7:0]  op_tok;
    logic [8*160-1:0] skip_buf;
    logic [31:0] f_id, f_addr, f_data, f_strb, f_rdata, f_resp, f_led;
    test_t       t;
    done = 1'b0;
    fd   = $fopen("verif/ps_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open verif/ps_tests.txt");
      err_count = err_count + 1;
      return;
    end
    while (!done) begin
      n = $fscanf(fd, "%s", op_tok);
      if (n != 1) begin
        done = 1'b1;
      end else if (op_tok == "#") begin
        // Comment line, drop the rest of it
        n = $fgets(skip_buf, fd);
      end else begin
        n = $fscanf(fd, "%h %h %h %h %h %h %h", f_id, f_addr, f_data, f_strb,
                    f_rdata, f_resp, f_led);
        if (n != 7) begin
          $display("Malformed line in tests file after %0d tests", tests.size());
          err_count = err_count + 1;
          done      = 1'b1;
        end else begin
          t.is_write  = (op_tok == "W");
          t.id        = f_id[11:0];
          t.addr      = f_addr;
          t.data      = f_data;
          t.strb      = f_strb[3:0];
          t.exp_rdata = f_rdata;
          t.exp_resp  = f_resp[1:0];
          t.exp_led   = f_led[LED_W-1:0];
          tests.push_back(t);
        end
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One AXI transaction with checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_test(input int idx, input test_t t);
    int                 stall;
    ps_bus_pkg::axi_r_t held;
    ps_bus_pkg::axi_r_t seen;
    test_bad = 1'b0;
    // Address phase, inputs change 1 ns after the edge
    @(posedge clk);
    #1;
    if (t.is_write) begin
      aw.id       = t.id;
      aw.addr     = t.addr;
      w.data      = t.data;
      w.strb      = t.strb;
      aw_valid    = 1'b1;
      w_valid     = 1'b1;
      waiting_for = "AWREADY";
    end else begin
      ar.id       = t.id;
      ar.addr     = t.addr;
      ar_valid    = 1'b1;
      waiting_for = "ARREADY";
    end
    @(negedge clk);
    while (!(aw_ready || ar_ready)) @(negedge clk);
    if (t.is_write && !w_ready) begin
      $display("Test %0d: WREADY did not rise together with AWREADY", idx);
      err_count = err_count + 1;
      test_bad  = 1'b1;
    end
    @(posedge clk);
    #1;
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    ar_valid = 1'b0;
    // Response phase
    if (t.is_write) waiting_for = "BVALID";
    else            waiting_for = "RVALID";
    @(negedge clk);
    while (!resp_valid(t.is_write)) @(negedge clk);
    held  = resp_view(t.is_write);
    stall = int'((lcg_next() >> 16) % 4);
    // Back-pressure, payload must hold
    repeat (stall) begin
      @(negedge clk);
      seen = resp_view(t.is_write);
      if (!resp_valid(t.is_write)) begin
        $display("Test %0d: response valid dropped while ready was low", idx);
        err_count = err_count + 1;
        test_bad  = 1'b1;
      end
      if (seen !== held) report_mismatch("stalled payload", $sformatf("%h", held),
                                         $sformatf("%h", seen));
    end
    @(posedge clk);
    #1;
    b_ready = t.is_write;
    r_ready = !t.is_write;
    @(negedge clk);
    seen = resp_view(t.is_write);
    if (seen.id !== t.id) report_mismatch(t.is_write ? "b.id" : "r.id",
                                          $sformatf("%h", t.id), $sformatf("%h", seen.id));
    if (seen.resp !== t.exp_resp) report_mismatch(t.is_write ? "b.resp" : "r.resp",
                                  $sformatf("%0d", t.exp_resp), $sformatf("%0d", seen.resp));
    if (!t.is_write && seen.data !== t.exp_rdata) report_mismatch("r.data",
                                  $sformatf("%h", t.exp_rdata), $sformatf("%h", seen.data));
    if (led !== t.exp_led) report_mismatch("led", $sformatf("%h", t.exp_led),
                                           $sformatf("%h", led));
    // Handshake edge, then the response must be gone
    @(posedge clk);
    #1;
    b_ready = 1'b0;
    r_ready = 1'b0;
    @(negedge clk);
    if (resp_valid(t.is_write)) begin
      $display("Test %0d: response still valid after its handshake", idx);
      err_count = err_count + 1;
      test_bad  = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n    = 1'b0;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    load_tests();
    if (tests.size() == 0) begin
      $display("No tests were read from the tests file");
      err_count = err_count + 1;
    end
    cycle_limit = 40 * tests.size() + 100;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Idle state straight out of reset
    @(negedge clk);
    if (led !== '0) report_mismatch("led", "00", $sformatf("%h", led));
    if (b_valid !== 1'b0) report_mismatch("b_valid", "0", $sformatf("%b", b_valid));
    if (r_valid !== 1'b0) report_mismatch("r_valid", "0", $sformatf("%b", r_valid));
    foreach (tests[i]) begin
      run_test(i, tests[i]);
      if (test_bad) fail_count = fail_count + 1;
      else          pass_count = pass_count + 1;
      $display("Test %0d %s id=%h addr=%h: %s", i, tests[i].is_write ? "W" : "R",
               tests[i].id, tests[i].addr, test_bad ? "failed" : "passed");
    end
    $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_count, fail_count, err_count);
    if (err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/ps_tests.txt
# op id addr data strb exp_rdata exp_resp exp_led, all hex except op (W or R)
# exp_rdata is ignored on writes; exp_resp 0 = OKAY, 2 = SLVERR
R 001 00000000 00000000 0 52500001 0 00
W 002 00000000 DEADBEEF F 00000000 0 00
R 003 00000000 00000000 0 52500001 0 00
W 004 00000008 11223344 F 00000000 0 00
W 005 00000008 AABBCCDD 5 00000000 0 00
R 006 00000008 00000000 0 11BB33DD 0 00
W 007 00000008 55667788 A 00000000 0 00
R 008 00000008 00000000 0 55BB77DD 0 00
W 009 00000004 000000A5 1 00000000 0 A5
R 00A 00000004 00000000 0 000000A5 0 A5
W 00B 00000004 0000003C 2 00000000 0 A5
R 00C 0000000C 00000000 0 00000000 0 A5
W 010 00100000 CAFEF00D F 00000000 0 A5
W 011 00100004 01234567 F 00000000 0 A5
W 012 001000FC 89ABCDEF F 00000000 0 A5
R 013 00100000 00000000 0 CAFEF00D 0 A5
R 014 00100100 00000000 0 CAFEF00D 0 A5
W 015 00100104 FFFF0000 C 00000000 0 A5
R 016 00100004 00000000 0 FFFF4567 0 A5
R 017 001000FC 00000000 0 89ABCDEF 0 A5
R 020 00500000 00000000 0 00000000 2 A5
W 021 00500010 12345678 F 00000000 2 A5
R 022 00100000 00000000 0 CAFEF00D 0 A5
R ABC 00000008 00000000 0 55BB77DD 0 A5
W FFF 00000008 00000000 0 00000000 0 A5

// File: verilog.f
rtl/ps_bus_pkg.sv
rtl/axi_gp_slave.sv
rtl/sys_bus_decoder.sv
rtl/housekeeping_regs.sv
rtl/sys_bus_ram.sv
rtl/ps_subsystem_top.sv
verif/ps_subsystem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PS subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f verilog.f --top-module ps_subsystem_tb \
  -o ps_subsystem_sim > build.log 2>&1 \
  && ./obj_dir/ps_subsystem_sim > "$LOG" 2>&1 \
  || { echo "Build or run failed, see build.log and $LOG"; exit 1; }

cat "$LOG"
grep -q "Done: errors found" "$LOG" && { echo "Simulation failed"; exit 1; }
grep -q "Done: no errors" "$LOG" || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
